/* Makefile */
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/100ps
TOP        := fp_add_tb
FILELIST   := src.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Some tests failed
PASS_MSG   := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/fp_add_params.svh */
// ~~~~~~~~~~~~~~~~~~~~
// Single precision format constants, shared by all stages
// ~~~~~~~~~~~~~~~~~~~~
`ifndef FP_ADD_PARAMS_SVH
`define FP_ADD_PARAMS_SVH

`define FP_EXP_W    8               // Exponent field width
`define FP_FRAC_W   23              // Stored fraction, hidden bit excluded
`define FP_BIAS     127             // Exponent bias
`define FP_EXP_MAX  8'd255          // All ones exponent, inf and NaN
`define FP_QNAN     32'h7FC0_0000   // Canonical quiet NaN
`define FP_GRS_W    3               // Guard, round and sticky bits

// Derived widths
`define FP_SIG_W    (`FP_FRAC_W + 1)            // Significand with hidden bit
`define FP_EXT_W    (`FP_SIG_W + `FP_GRS_W)     // Significand plus GRS

`endif

/* common/fp_add_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Types for the three stage adder, binary32 layout only
// ~~~~~~~~~~~~~~~~~~~~
`include "fp_add_params.svh"

package fp_add_pkg;

    // Field view of a float word
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;
    } fp_fields_t;

    // Magnitude view, exponent and fraction order like an unsigned integer
    typedef struct packed {
        logic                            sign;
        logic [`FP_EXP_W+`FP_FRAC_W-1:0] mag;
    } fp_mag_t;

    typedef union packed {
        fp_fields_t f;
        fp_mag_t    m;
    } fp_word_u;

    // Outcome of special case detection
    typedef enum logic [2:0] {
        sp_none,        // Plain arithmetic
        sp_zero,        // x - x, exact +0
        sp_zero_op,     // One zero operand, other one passes
        sp_both_zero,   // 0 + 0 with signed zero rule
        sp_inf,
        sp_nan
    } sp_class_t;

    // Stage 1 to stage 2
    typedef struct packed {
        fp_word_u             a;
        fp_word_u             b;
        logic [`FP_EXP_W-1:0] exp_a;    // Subnormals forced to 1
        logic [`FP_EXP_W-1:0] exp_b;
        logic [`FP_SIG_W-1:0] sig_a;    // Hidden bit included
        logic [`FP_SIG_W-1:0] sig_b;
        logic                 eff_sub;
        logic                 sign_b;   // Sign of b after op_sub
        sp_class_t            sp;
        fp_word_u             sp_word;
        logic                 invalid;
    } det_pay_t;

    // Stage 2 to stage 3
    typedef struct packed {
        logic                 sign;
        logic [`FP_EXP_W-1:0] exp;          // Exponent of larger operand
        logic [`FP_SIG_W-1:0] sig_big;
        logic [`FP_EXT_W-1:0] sig_small;    // Aligned, GRS at the bottom
        logic                 eff_sub;
        sp_class_t            sp;
        fp_word_u             sp_word;
        logic                 invalid;
    } aln_pay_t;

endpackage

/* common/fp_stage_if.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Valid/ready link, payload held stable until taken
// ~~~~~~~~~~~~~~~~~~~~
interface fp_stage_if #(
    parameter type pay_t = logic    // Stage payload struct
);

    logic valid;    // Payload present
    logic ready;    // Downstream can take it this cycle
    pay_t payload;

    // Producing stage
    modport src (
        output valid,
        output payload,
        input  ready
    );

    // Consuming stage
    modport dst (
        input  valid,
        input  payload,
        output ready
    );

endinterface

/* fp_add/fp_align.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Stage 2, gaps of 26 or more keep only sticky
// ~~~~~~~~~~~~~~~~~~~~
`include "fp_add_params.svh"

module fp_align
    import fp_add_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    fp_stage_if.dst det_in,
    fp_stage_if.src aln_out
);

    det_pay_t             p;
    aln_pay_t             nxt;
    logic                 a_big;        // a has the larger magnitude
    logic [`FP_EXP_W-1:0] e_small;
    logic [`FP_EXP_W-1:0] diff;
    logic [`FP_SIG_W-1:0] sig_small;
    logic [`FP_EXT_W-1:0] ext_small;
    logic [`FP_EXT_W-1:0] lost_mask;    // Bits shifted below sticky
    logic [`FP_EXT_W-1:0] shifted;

    assign p = det_in.payload;

    // Magnitude view orders finite floats like integers
    assign a_big = p.a.m.mag >= p.b.m.mag;

    always_comb begin
        nxt.eff_sub = p.eff_sub;
        nxt.sp      = p.sp;         // Specials pass untouched
        nxt.sp_word = p.sp_word;
        nxt.invalid = p.invalid;

        if (a_big) begin
            nxt.sign    = p.a.f.sign;
            nxt.exp     = p.exp_a;
            nxt.sig_big = p.sig_a;
            e_small     = p.exp_b;
            sig_small   = p.sig_b;
        end else begin
            nxt.sign    = p.sign_b;     // Op already folded into b
            nxt.exp     = p.exp_b;
            nxt.sig_big = p.sig_b;
            e_small     = p.exp_a;
            sig_small   = p.sig_a;
        end

        diff      = nxt.exp - e_small;  // Never negative after the swap
        ext_small = {sig_small, {`FP_GRS_W{1'b0}}};
        lost_mask = ~({`FP_EXT_W{1'b1}} << diff);
        shifted   = ext_small >> diff;

        if (diff >= `FP_EXP_W'(26)) begin
            // Everything lands below the round bit
            nxt.sig_small = {{(`FP_EXT_W-1){1'b0}}, |sig_small};
        end else begin
            nxt.sig_small = shifted | {{(`FP_EXT_W-1){1'b0}}, |(ext_small & lost_mask)};
        end
    end

    assign det_in.ready = !aln_out.valid || aln_out.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            aln_out.valid <= 1'b0;
        end else if (det_in.ready) begin
            aln_out.valid <= det_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (det_in.valid && det_in.ready) begin
            aln_out.payload <= nxt;
        end
    end

endmodule

/* fp_add/fp_special_detect.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Stage 1, NaN outputs are always the canonical quiet NaN
// ~~~~~~~~~~~~~~~~~~~~
`include "fp_add_params.svh"

module fp_special_detect
    import fp_add_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  logic     op_sub,
    input  fp_word_u a,
    input  fp_word_u b,
    fp_stage_if.src  det_out
);

    logic a_zero, a_sub, a_inf, a_nan;
    logic b_zero, b_sub, b_inf, b_nan;
    logic sign_b;       // b as seen by an addition
    logic eff_sub;      // Signs differ after op_sub
    det_pay_t nxt;

    // Operand classes
    assign a_zero = (a.f.exp == '0) && (a.f.frac == '0);
    assign a_sub  = (a.f.exp == '0) && (a.f.frac != '0);
    assign a_inf  = (a.f.exp == `FP_EXP_MAX) && (a.f.frac == '0);
    assign a_nan  = (a.f.exp == `FP_EXP_MAX) && (a.f.frac != '0);
    assign b_zero = (b.f.exp == '0) && (b.f.frac == '0);
    assign b_sub  = (b.f.exp == '0) && (b.f.frac != '0);
    assign b_inf  = (b.f.exp == `FP_EXP_MAX) && (b.f.frac == '0);
    assign b_nan  = (b.f.exp == `FP_EXP_MAX) && (b.f.frac != '0);

    assign sign_b  = b.f.sign ^ op_sub;
    assign eff_sub = a.f.sign ^ sign_b;

    always_comb begin
        nxt.a       = a;
        nxt.b       = b;
        nxt.eff_sub = eff_sub;
        nxt.sign_b  = sign_b;
        nxt.invalid = 1'b0;
        nxt.sp_word = '0;

        // Subnormals sit at exponent 1 without the hidden one
        nxt.exp_a = a_sub ? `FP_EXP_W'(1) : a.f.exp;
        nxt.exp_b = b_sub ? `FP_EXP_W'(1) : b.f.exp;
        nxt.sig_a = {a.f.exp != '0, a.f.frac};
        nxt.sig_b = {b.f.exp != '0, b.f.frac};

        // First matching case wins
        if (a_nan || b_nan) begin
            nxt.sp      = sp_nan;
            nxt.sp_word = `FP_QNAN;
        end else if (a_inf && b_inf && eff_sub) begin
            nxt.sp      = sp_nan;       // inf - inf
            nxt.sp_word = `FP_QNAN;
            nxt.invalid = 1'b1;
        end else if (a_inf || b_inf) begin
            nxt.sp      = sp_inf;       // Both infs share a sign here
            nxt.sp_word = {a_inf ? a.f.sign : sign_b, `FP_EXP_MAX, {`FP_FRAC_W{1'b0}}};
        end else if ((a.m.mag == b.m.mag) && eff_sub) begin
            nxt.sp      = sp_zero;      // Exact cancellation gives +0
            nxt.sp_word = '0;
        end else if (a_zero && b_zero) begin
            nxt.sp      = sp_both_zero;
            nxt.sp_word = {a.f.sign & sign_b, {(`FP_EXP_W+`FP_FRAC_W){1'b0}}};
        end else if (a_zero) begin
            nxt.sp      = sp_zero_op;
            nxt.sp_word = {sign_b, b.m.mag};    // b with the op applied
        end else if (b_zero) begin
            nxt.sp      = sp_zero_op;
            nxt.sp_word = a;
        end else begin
            nxt.sp      = sp_none;
        end
    end

    // Register is free or being drained this cycle
    assign in_ready = !det_out.valid || det_out.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            det_out.valid <= 1'b0;
        end else if (in_ready) begin
            det_out.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            det_out.payload <= nxt;
        end
    end

endmodule

/* fp_add/fp_sum_round.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Stage 3, nearest even only, underflow gives subnormals
// ~~~~~~~~~~~~~~~~~~~~
`include "fp_add_params.svh"

module fp_sum_round
    import fp_add_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    fp_stage_if.dst  aln_in,
    output logic     out_valid,
    output fp_word_u result,
    output logic     invalid,
    input  logic     out_ready
);

    aln_pay_t              p;
    logic [`FP_EXT_W-1:0]  big_ext;
    logic [`FP_EXT_W:0]    sum;         // Extra top bit for carry out
    logic [`FP_EXT_W-1:0]  norm;
    logic [4:0]            lz;          // Leading zeros of sum
    logic [4:0]            shamt;
    logic [`FP_EXP_W-1:0]  e_room;      // Left shift allowed before exp 1
    logic [`FP_EXP_W:0]    e_norm;      // One spare bit for overflow
    logic [`FP_EXP_W:0]    e_fin;
    logic                  rnd_up;
    logic [`FP_SIG_W:0]    rounded;
    logic [`FP_FRAC_W-1:0] frac;
    fp_word_u              arith;
    fp_word_u              res_nxt;

    assign p = aln_in.payload;

    always_comb begin
        big_ext = {p.sig_big, {`FP_GRS_W{1'b0}}};
        if (p.eff_sub) begin
            sum = {1'b0, big_ext} - {1'b0, p.sig_small};   // Larger minus smaller
        end else begin
            sum = {1'b0, big_ext} + {1'b0, p.sig_small};
        end

        // Last hit is the highest set bit
        lz = 5'(`FP_EXT_W);
        for (int i = 0; i < `FP_EXT_W; i++) begin
            if (sum[i]) lz = 5'(`FP_EXT_W - 1 - i);
        end

        e_room = p.exp - 1'b1;

        if (sum[`FP_EXT_W]) begin
            // Carry out, one step right, dropped bit joins sticky
            norm   = {sum[`FP_EXT_W:2], sum[1] | sum[0]};
            e_norm = {1'b0, p.exp} + 1'b1;
            shamt  = '0;
        end else begin
            // Cancellation, stop at exp 1 so small results go subnormal
            shamt  = ({3'b000, lz} > e_room) ? e_room[4:0] : lz;
            norm   = sum[`FP_EXT_W-1:0] << shamt;
            e_norm = {1'b0, p.exp} - shamt;
        end

        // Guard and (round or sticky or lsb)
        rnd_up  = norm[2] & (norm[1] | norm[0] | norm[3]);
        rounded = {1'b0, norm[`FP_EXT_W-1:`FP_GRS_W]} + rnd_up;

        if (rounded[`FP_SIG_W]) begin
            e_fin = e_norm + 1'b1;              // Rounding carried out
            frac  = rounded[`FP_SIG_W-1:1];
        end else begin
            e_fin = rounded[`FP_SIG_W-1] ? e_norm : '0;    // No hidden bit, subnormal
            frac  = rounded[`FP_FRAC_W-1:0];
        end

        if (e_fin >= {1'b0, `FP_EXP_MAX}) begin
            arith = {p.sign, `FP_EXP_MAX, {`FP_FRAC_W{1'b0}}};  // Overflow to inf
        end else begin
            arith = {p.sign, e_fin[`FP_EXP_W-1:0], frac};
        end

        res_nxt = (p.sp == sp_none) ? arith : p.sp_word;
    end

    assign aln_in.ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (aln_in.ready) begin
            out_valid <= aln_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (aln_in.valid && aln_in.ready) begin
            result  <= res_nxt;
            invalid <= p.invalid;
        end
    end

endmodule

/* source/fp_add_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Three cycle latency, at most three results held under stall
// ~~~~~~~~~~~~~~~~~~~~
module fp_add_top
    import fp_add_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  logic        op_sub,     // 1 gives a - b
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] result,
    output logic        invalid     // Set only for inf - inf
);

    // Detect to align, then align to sum
    fp_stage_if #(.pay_t(det_pay_t)) det_if ();
    fp_stage_if #(.pay_t(aln_pay_t)) aln_if ();

    fp_special_detect u_detect (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .op_sub   (op_sub),
        .a        (a),
        .b        (b),
        .det_out  (det_if.src)
    );

    fp_align u_align (
        .clk      (clk),
        .reset    (reset),
        .det_in   (det_if.dst),
        .aln_out  (aln_if.src)
    );

    fp_sum_round u_sum (
        .clk       (clk),
        .reset     (reset),
        .aln_in    (aln_if.dst),
        .out_valid (out_valid),
        .result    (result),
        .invalid   (invalid),
        .out_ready (out_ready)
    );

endmodule

/* src.f */
+incdir+common
common/fp_add_pkg.sv
common/fp_stage_if.sv
fp_add/fp_special_detect.sv
fp_add/fp_align.sv
fp_add/fp_sum_round.sv
source/fp_add_top.sv
test/fp_add_checker.sv
test/fp_add_tb.sv

/* test/fp_add_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Output handshake assertions, bound into every fp_add_top
// ~~~~~~~~~~~~~~~~~~~~
`include "fp_add_params.svh"

module fp_add_checker (
    input logic        clk,
    input logic        reset,
    input logic        out_valid,
    input logic        out_ready,
    input logic [31:0] result,
    input logic        invalid
);
    timeunit 1ns;
    timeprecision 100ps;

    // A stalled result must wait unchanged
    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(result) && $stable(invalid))
        else $error("output word or valid changed while out_ready was low");

    // Output register empties in reset
    a_reset_clear: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // Only inf - inf sets invalid, and that always gives the quiet NaN
    a_invalid_nan: assert property (@(posedge clk) disable iff (reset)
        out_valid && invalid |-> result == `FP_QNAN)
        else $error("invalid set on a result that is not the canonical NaN");

endmodule

bind fp_add_top fp_add_checker i_checker (
    .clk       (clk),
    .reset     (reset),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result),
    .invalid   (invalid)
);

/* test/fp_add_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Vectors from test/fp_add_testdata.txt, run from the project root
// ~~~~~~~~~~~~~~~~~~~~
module fp_add_tb
    import fp_add_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic     op_sub;
        fp_word_u a;
        fp_word_u b;
        fp_word_u result;   // Expected word
        logic     invalid;  // Expected flag
    } vector_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    logic        op_sub;
    fp_word_u    a;
    fp_word_u    b;
    logic        out_valid;
    logic        out_ready = 1'b0;
    logic [31:0] result;
    logic        invalid;

    vector_t     vectors[$];
    vector_t     expected_q[$];     // Accepted, not yet retired
    vector_t     current;           // Vector on the input pins
    int          accepted = 0;
    int          retired = 0;
    logic        throttle;          // Random out_ready when set
    logic [31:0] lfsr_state = 32'h75cb8c29;

    fp_add_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op_sub    (op_sub),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result),
        .invalid   (invalid)
    );

    always #20 clk = ~clk;  // 40 ns period

    // Galois form, one step per random bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input fp_word_u exp_w, input fp_word_u act_w);
        if (act_w !== exp_w) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp_w, act_w);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp_f, input logic act_f);
        if (act_f !== exp_f) begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp_f, act_f);
            abort_run();
        end
    endtask

    task automatic load_vectors();
        int          fd;
        string       line;
        vector_t     v;
        logic [31:0] f_op, f_a, f_b, f_r, f_i;
        fd = $fopen("test/fp_add_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open test/fp_add_testdata.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;   // Comment or blank
            if ($sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_r, f_i) != 5) continue;
            v.op_sub  = f_op[0];
            v.a       = f_a;
            v.b       = f_b;
            v.result  = f_r;
            v.invalid = f_i[0];
            vectors.push_back(v);
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("the test data file holds no vectors");
            abort_run();
        end
    endtask

    // Called 1 ns after a rising edge, returns in the same slot
    task automatic send_vector(input vector_t v);
        int waited;
        current  = v;
        in_valid = 1'b1;
        op_sub   = v.op_sub;
        a        = v.a;
        b        = v.b;
        waited   = 0;
        @(negedge clk);
        while (!in_ready) begin
            if (!throttle) begin
                $display("in_ready dropped although out_ready was held high");
                abort_run();
            end
            waited++;
            if (waited > 200) begin
                $display("timed out waiting for in_ready");
                abort_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (retired != accepted) begin
            @(posedge clk);
            cycles++;
            if (cycles > 200) begin
                $display("timed out waiting for out_valid, results are missing");
                abort_run();
            end
        end
        @(posedge clk);
        #1;
    endtask

    // out_ready changes 1 ns after each edge
    always @(posedge clk) begin
        #1;
        if (throttle) begin
            lfsr_state = lfsr_step(lfsr_state);
            out_ready  = lfsr_state[0];
        end else begin
            out_ready = 1'b1;
        end
    end

    // Sample mid cycle, where every handshake signal is settled
    always @(negedge clk) begin
        vector_t exp_v;
        if (!reset) begin
            if (!in_ready && (accepted - retired) != 3) begin
                $display("in_ready low while fewer than three operations were held");
                abort_run();
            end
            if (in_valid && in_ready) begin
                expected_q.push_back(current);
                accepted++;
            end
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    $display("a result came out with no operation outstanding");
                    abort_run();
                end
                exp_v = expected_q.pop_front();
                check_word("result", exp_v.result, fp_word_u'(result));
                check_flag("invalid", exp_v.invalid, invalid);
                retired++;
            end
        end
    end

    initial begin
        reset    = 1'b1;
        in_valid = 1'b0;
        op_sub   = 1'b0;
        a        = '0;
        b        = '0;
        throttle = 1'b1;
        load_vectors();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // Random back-pressure
        foreach (vectors[i]) send_vector(vectors[i]);
        in_valid = 1'b0;
        wait_drain();

        // Full rate, out_ready held high
        throttle = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        foreach (vectors[i]) send_vector(vectors[i]);
        in_valid = 1'b0;
        wait_drain();

        $display("All tests passed");
        $finish;
    end

endmodule

/* test/fp_add_testdata.txt */
# Columns: op_sub (1 gives a - b), a, b, expected result, expected invalid; all hex
# Lines starting with # are skipped
0 3F800000 3F800000 40000000 0
0 3FC00000 40100000 40700000 0
1 40400000 40A00000 C0000000 0
0 C1000000 3F000000 C0F00000 0
1 3F800001 3F800000 34000000 0
1 3F800000 33800000 3F7FFFFF 0
0 3F800000 32800000 3F800000 0
1 3F800000 30800000 3F800000 0
0 3F800000 33800000 3F800000 0
0 3F800001 33800000 3F800002 0
0 3F800000 33C00000 3F800001 0
0 3FFFFFFF 33800000 40000000 0
0 00000001 00000001 00000002 0
0 00400000 00400000 00800000 0
1 00800001 00800000 00000001 0
1 01000000 00800001 007FFFFF 0
0 7FC00000 3F800000 7FC00000 0
0 FFC00000 7F800000 7FC00000 0
0 7F800000 3F800000 7F800000 0
1 3F800000 7F800000 FF800000 0
1 7F800000 7F800000 7FC00000 1
0 FF800000 7F800000 7FC00000 1
0 7F7FFFFF 7F7FFFFF 7F800000 0
0 7F7FFFFF 73000000 7F800000 0
1 40490FDB 40490FDB 00000000 0
1 00000000 40400000 C0400000 0
1 40A00000 00000000 40A00000 0
0 80000000 80000000 80000000 0
0 00000000 80000000 00000000 0
